//--- adc_fe_pkg.sv
`default_nettype none

package adc_fe_pkg;

	////////////////////
	// Data widths
	////////////////////

	// One ADC channel sample
	localparam int ADC_W      = 14;
	// One preamp gain code
	localparam int GAIN_W     = 4;
	// Preamp serial word, gain B over gain A
	localparam int AMP_WORD_W = 8;
	// LED bank
	localparam int LED_W      = 8;
	// Sample period value
	localparam int CNT_W      = 32;

	////////////////////
	// Serial timing
	////////////////////

	// System clocks per half serial clock, shared by both links
	localparam int SCK_HALF   = 2;

	////////////////////
	// Types
	////////////////////

	// Switch codes for the LED byte select
	typedef enum logic [3:0] {
		SEL_A_LO = 4'h1,
		SEL_A_HI = 4'h2,
		SEL_AMP  = 4'h3,
		SEL_B_LO = 4'h4,
		SEL_B_HI = 4'h8
	} led_sel_t;

	// Controller states
	typedef enum logic [1:0] {
		RESTART        = 2'd0,
		AMP_SENDING    = 2'd1,
		ADC_CONVERTING = 2'd2
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- adc_frontend.f
adc_fe_pkg.sv
sample_counter.sv
amp_spi.sv
adc_spi.sv
cntr.sv
adc_frontend.sv
tb_clock.sv
tb_adc_frontend.sv

//--- adc_frontend.sv
`timescale 1ns/10ps
`default_nettype none

module adc_frontend #(
	parameter logic [adc_fe_pkg::GAIN_W-1:0] GAIN_A        = 4'd4,
	parameter logic [adc_fe_pkg::GAIN_W-1:0] GAIN_B        = 4'd2,
	parameter logic [adc_fe_pkg::CNT_W-1:0]  SAMPLE_PERIOD = 100_000_000
) (
	input  wire                                    CLK50MHZ,
	input  wire                                    RST,
	input  wire [$bits(adc_fe_pkg::led_sel_t)-1:0] sw,
	output wire [adc_fe_pkg::LED_W-1:0]            led,
	// Preamp pins
	output wire                                    amp_sck,
	output wire                                    amp_cs,
	output wire                                    amp_mosi,
	input  wire                                    amp_miso,
	// ADC pins
	output wire                                    ad_conv,
	output wire                                    adc_sck,
	input  wire                                    adc_miso
);
	import adc_fe_pkg::*;

	// Controller to preamp engine
	wire                  amp_trig;
	wire [GAIN_W-1:0]     amp_a;
	wire [GAIN_W-1:0]     amp_b;
	wire                  amp_done;
	wire [AMP_WORD_W-1:0] amp_rx;
	// Controller to ADC engine
	wire                  adc_trig;
	wire                  adc_done;
	wire [ADC_W-1:0]      adc_a;
	wire [ADC_W-1:0]      adc_b;

	cntr #(
		.GAIN_A        (GAIN_A),
		.GAIN_B        (GAIN_B),
		.SAMPLE_PERIOD (SAMPLE_PERIOD)
	) u_cntr (
		.CLK50MHZ         (CLK50MHZ),
		.RST              (RST),
		.amp_trig         (amp_trig),
		.amp_a            (amp_a),
		.amp_b            (amp_b),
		.amp_done         (amp_done),
		.amp_datareceived (amp_rx),
		.adc_trig         (adc_trig),
		.adc_done         (adc_done),
		.adc_a            (adc_a),
		.adc_b            (adc_b),
		.sw               (sw),
		.led              (led)
	);

	// Gain word writer
	amp_spi u_amp_spi (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.amp_trig (amp_trig),
		.gain_a   (amp_a),
		.gain_b   (amp_b),
		.amp_done (amp_done),
		.amp_rx   (amp_rx),
		.amp_sck  (amp_sck),
		.amp_cs   (amp_cs),
		.amp_mosi (amp_mosi),
		.amp_miso (amp_miso)
	);

	// Dual channel sample reader
	adc_spi u_adc_spi (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.adc_trig (adc_trig),
		.adc_done (adc_done),
		.adc_a    (adc_a),
		.adc_b    (adc_b),
		.ad_conv  (ad_conv),
		.adc_sck  (adc_sck),
		.adc_miso (adc_miso)
	);

endmodule

`default_nettype wire

//--- adc_spi.sv
`timescale 1ns/10ps
`default_nettype none

module adc_spi (
	input  wire                          CLK50MHZ,
	input  wire                          RST,
	input  wire                          adc_trig,
	output logic                         adc_done,
	output logic [adc_fe_pkg::ADC_W-1:0] adc_a,
	output logic [adc_fe_pkg::ADC_W-1:0] adc_b,
	output logic                         ad_conv,
	output logic                         adc_sck,
	input  wire                          adc_miso
);
	import adc_fe_pkg::*;

	// Serial clocks per conversion read
	localparam int FRAME_W = 34;
	localparam int DIV_W   = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;
	localparam int BIT_W   = $clog2(FRAME_W);
	// Field positions in the frame, bit 1 arrives first
	localparam int A_MSB   = FRAME_W - 3;
	localparam int B_MSB   = FRAME_W - 19;

	typedef enum logic [1:0] {
		AD_IDLE,
		AD_CONV,
		AD_SHIFT,
		AD_FIN
	} adc_state_t;

	adc_state_t state;

	// Half period divider
	logic [DIV_W-1:0] div;
	// Second half of the conversion pulse
	logic conv_half;
	// Serial clock index within the frame
	logic [BIT_W-1:0] bit_cnt;
	// Whole frame, first bit ends at the top
	logic [FRAME_W-1:0] sh;

	wire half_tick = (div == DIV_W'(SCK_HALF - 1));

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state     <= AD_IDLE;
			div       <= '0;
			conv_half <= 1'b0;
			bit_cnt   <= '0;
			ad_conv   <= 1'b0;
			adc_sck   <= 1'b0;
			adc_done  <= 1'b0;
		end else begin
			adc_done <= 1'b0;
			// Divider stopped in idle
			if (state != AD_IDLE && !half_tick) begin
				div <= div + 1'b1;
			end else begin
				div <= '0;
			end
			case (state)
				AD_IDLE: begin
					// Trigger while busy never reaches here
					if (adc_trig) begin
						state     <= AD_CONV;
						ad_conv   <= 1'b1;
						conv_half <= 1'b0;
					end
				end
				AD_CONV: begin
					// Convert pulse lasts one serial period
					if (half_tick) begin
						conv_half <= 1'b1;
						if (conv_half) begin
							ad_conv <= 1'b0;
							bit_cnt <= '0;
							state   <= AD_SHIFT;
						end
					end
				end
				AD_SHIFT: begin
					if (half_tick) begin
						adc_sck <= ~adc_sck;
						// Falling edge ends a serial clock
						if (adc_sck) begin
							if (bit_cnt == BIT_W'(FRAME_W - 1)) begin
								state <= AD_FIN;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end
				end
				AD_FIN: begin
					adc_done <= 1'b1;
					state    <= AD_IDLE;
				end
				default: state <= AD_IDLE;
			endcase
		end
	end

	////////////////////
	// Data path
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		// Sample on rising serial clock
		if (state == AD_SHIFT && half_tick && !adc_sck) begin
			sh <= {sh[FRAME_W-2:0], adc_miso};
		end
		// Channel fields, guard bits dropped
		if (state == AD_FIN) begin
			adc_a <= sh[A_MSB -: ADC_W];
			adc_b <= sh[B_MSB -: ADC_W];
		end
	end

endmodule

`default_nettype wire

//--- amp_spi.sv
`timescale 1ns/10ps
`default_nettype none

module amp_spi (
	input  wire                              CLK50MHZ,
	input  wire                              RST,
	input  wire                              amp_trig,
	input  wire [adc_fe_pkg::GAIN_W-1:0]     gain_a,
	input  wire [adc_fe_pkg::GAIN_W-1:0]     gain_b,
	output logic                             amp_done,
	output logic [adc_fe_pkg::AMP_WORD_W-1:0] amp_rx,
	output logic                             amp_sck,
	output logic                             amp_cs,
	output wire                              amp_mosi,
	input  wire                              amp_miso
);
	import adc_fe_pkg::*;

	localparam int DIV_W = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;
	localparam int BIT_W = $clog2(AMP_WORD_W);

	typedef enum logic [1:0] {
		AS_IDLE,
		AS_SHIFT,
		AS_FIN
	} amp_state_t;

	amp_state_t state;

	// Half period divider
	logic [DIV_W-1:0] div;
	// Bit index within the word
	logic [BIT_W-1:0] bit_cnt;
	// Outgoing word, incoming bits fill from the bottom
	logic [AMP_WORD_W-1:0] sh;
	// Returned bit held from rising to falling edge
	logic miso_q;

	wire half_tick = (div == DIV_W'(SCK_HALF - 1));

	// MSB of the shifter is always on the wire
	assign amp_mosi = sh[AMP_WORD_W-1];

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state    <= AS_IDLE;
			div      <= '0;
			bit_cnt  <= '0;
			amp_sck  <= 1'b0;
			amp_cs   <= 1'b1;
			amp_done <= 1'b0;
		end else begin
			amp_done <= 1'b0;
			// Divider only runs while shifting
			if (state == AS_SHIFT && !half_tick) begin
				div <= div + 1'b1;
			end else begin
				div <= '0;
			end
			case (state)
				AS_IDLE: begin
					if (amp_trig) begin
						state   <= AS_SHIFT;
						amp_cs  <= 1'b0;
						bit_cnt <= '0;
					end
				end
				AS_SHIFT: begin
					if (half_tick) begin
						amp_sck <= ~amp_sck;
						// Falling edge closes one bit
						if (amp_sck) begin
							if (bit_cnt == BIT_W'(AMP_WORD_W - 1)) begin
								state <= AS_FIN;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end
				end
				AS_FIN: begin
					// Release chip select, flag the word
					amp_done <= 1'b1;
					amp_cs   <= 1'b1;
					state    <= AS_IDLE;
				end
				default: state <= AS_IDLE;
			endcase
		end
	end

	////////////////////
	// Data path
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (state == AS_IDLE && amp_trig) begin
			// Gain B high nibble, gain A low nibble
			sh <= {gain_b, gain_a};
		end else if (state == AS_SHIFT && half_tick) begin
			if (!amp_sck) begin
				// Rising edge, sample the amp
				miso_q <= amp_miso;
			end else begin
				// Falling edge, next bit out
				sh <= {sh[AMP_WORD_W-2:0], miso_q};
			end
		end
		// Readback is what shifted in
		if (state == AS_FIN) begin
			amp_rx <= sh;
		end
	end

endmodule

`default_nettype wire

//--- cntr.sv
`timescale 1ns/10ps
`default_nettype none

module cntr #(
	parameter logic [adc_fe_pkg::GAIN_W-1:0] GAIN_A        = 4'd4,
	parameter logic [adc_fe_pkg::GAIN_W-1:0] GAIN_B        = 4'd2,
	parameter logic [adc_fe_pkg::CNT_W-1:0]  SAMPLE_PERIOD = 100_000_000
) (
	input  wire                                    CLK50MHZ,
	input  wire                                    RST,
	// Preamp link
	output logic                                   amp_trig,
	output wire [adc_fe_pkg::GAIN_W-1:0]           amp_a,
	output wire [adc_fe_pkg::GAIN_W-1:0]           amp_b,
	input  wire                                    amp_done,
	input  wire [adc_fe_pkg::AMP_WORD_W-1:0]       amp_datareceived,
	// ADC link
	output wire                                    adc_trig,
	input  wire                                    adc_done,
	input  wire [adc_fe_pkg::ADC_W-1:0]            adc_a,
	input  wire [adc_fe_pkg::ADC_W-1:0]            adc_b,
	// Board IO
	input  wire [$bits(adc_fe_pkg::led_sel_t)-1:0] sw,
	output logic [adc_fe_pkg::LED_W-1:0]           led
);
	import adc_fe_pkg::*;

	ctrl_state_t state;

	// Sample rate counter
	wire [CNT_W-1:0] cnt_max = SAMPLE_PERIOD;
	wire             cnt_en;

	assign amp_a = GAIN_A;
	assign amp_b = GAIN_B;

	// Conversions only after the preamp is set up
	assign cnt_en = (state == ADC_CONVERTING);

	sample_counter u_sample_counter (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.cnt_en   (cnt_en),
		.cnt_max  (cnt_max),
		.cnt_trig (adc_trig)
	);

	////////////////////
	// State machine
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state    <= RESTART;
			amp_trig <= 1'b0;
		end else begin
			// One gain write per reset
			amp_trig <= (state == RESTART);
			case (state)
				RESTART: begin
					state <= AMP_SENDING;
				end
				AMP_SENDING: begin
					// Wait for the preamp word to finish
					if (amp_done) begin
						state <= ADC_CONVERTING;
					end
				end
				ADC_CONVERTING: begin
					// Free running until reset
					state <= ADC_CONVERTING;
				end
				default: state <= RESTART;
			endcase
		end
	end

	////////////////////
	// LED select
	////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			led <= LED_W'(8'hAA);
		end else if (adc_done) begin
			case (sw)
				SEL_A_LO: led <= adc_a[7:0];
				// Upper six bits, zero filled
				SEL_A_HI: led <= LED_W'(adc_a[ADC_W-1:8]);
				SEL_B_LO: led <= adc_b[7:0];
				SEL_B_HI: led <= LED_W'(adc_b[ADC_W-1:8]);
				// Preamp readback byte
				SEL_AMP:  led <= LED_W'(amp_datareceived);
				default:  led <= LED_W'(8'h55);
			endcase
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run with Verilator, result decided by the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/10ps --top-module tb_adc_frontend \
	-f adc_frontend.f || exit 1
out=$(./obj_dir/Vtb_adc_frontend 2>&1)
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1

//--- sample_counter.sv
`timescale 1ns/10ps
`default_nettype none

module sample_counter (
	input  wire                         CLK50MHZ,
	input  wire                         RST,
	input  wire                         cnt_en,
	input  wire [adc_fe_pkg::CNT_W-1:0] cnt_max,
	output logic                        cnt_trig
);
	import adc_fe_pkg::*;

	// Clocks left until the next tick
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			cnt      <= '0;
			cnt_trig <= 1'b0;
		end else if (!cnt_en) begin
			// Parked at reload value while off
			// First tick then lands a full period after enable
			cnt      <= cnt_max - 1'b1;
			cnt_trig <= 1'b0;
		end else if (cnt == '0) begin
			// Period done, reload and fire
			cnt      <= cnt_max - 1'b1;
			cnt_trig <= 1'b1;
		end else begin
			cnt      <= cnt - 1'b1;
			cnt_trig <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- tb_adc_frontend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_adc_frontend;
	import adc_fe_pkg::*;

	localparam logic [GAIN_W-1:0]     GAIN_A        = 4'd4;
	localparam logic [GAIN_W-1:0]     GAIN_B        = 4'd2;
	localparam int                    SAMPLE_PERIOD = 200;
	// Byte the preamp model sends back
	localparam logic [AMP_WORD_W-1:0] AMP_READBACK  = 8'h5A;
	localparam logic [LED_W-1:0]      LED_RESET     = 8'hAA;
	localparam logic [LED_W-1:0]      LED_OTHER     = 8'h55;

	wire                           CLK50MHZ;
	wire                           por_rst;
	logic                          mid_rst = 1'b0;
	wire                           dut_rst = por_rst | mid_rst;
	logic [$bits(led_sel_t)-1:0]   sw;
	wire  [LED_W-1:0]              led;
	wire                           amp_sck;
	wire                           amp_cs;
	wire                           amp_mosi;
	wire                           amp_miso;
	wire                           ad_conv;
	wire                           adc_sck;
	wire                           adc_miso;

	tb_clock #(.PERIOD(20), .RST_CYCLES(16)) u_clock (
		.CLK50MHZ (CLK50MHZ),
		.RST      (por_rst)
	);

	adc_frontend #(
		.GAIN_A        (GAIN_A),
		.GAIN_B        (GAIN_B),
		.SAMPLE_PERIOD (SAMPLE_PERIOD)
	) i_dut (
		.CLK50MHZ (CLK50MHZ),
		.RST      (dut_rst),
		.sw       (sw),
		.led      (led),
		.amp_sck  (amp_sck),
		.amp_cs   (amp_cs),
		.amp_mosi (amp_mosi),
		.amp_miso (amp_miso),
		.ad_conv  (ad_conv),
		.adc_sck  (adc_sck),
		.adc_miso (adc_miso)
	);

	////////////////////
	// Preamp model
	////////////////////

	logic [AMP_WORD_W-1:0] amp_shift  = '0;
	logic [AMP_WORD_W-1:0] amp_word   = '0;
	logic [AMP_WORD_W-1:0] amp_rb     = AMP_READBACK;
	int                    amp_bits   = 0;
	int                    amp_frames = 0;
	int                    amp_words  = 0;

	// Readback MSB sits on the line before chip select drops
	assign amp_miso = amp_rb[AMP_WORD_W-1];

	// Chip select fall opens a frame, rising serial clock takes a bit
	always @(posedge amp_sck or negedge amp_cs) begin
		if (!amp_sck) begin
			amp_shift  = '0;
			amp_bits   = 0;
			amp_frames = amp_frames + 1;
		end else if (!amp_cs) begin
			amp_shift = {amp_shift[AMP_WORD_W-2:0], amp_mosi};
			amp_bits  = amp_bits + 1;
		end
	end

	// Next readback bit on falling serial clock, reload at frame end
	always @(negedge amp_sck or posedge amp_cs) begin
		if (amp_cs) begin
			amp_rb = AMP_READBACK;
		end else begin
			amp_rb = {amp_rb[AMP_WORD_W-2:0], 1'b0};
		end
	end

	// Word complete when chip select returns high
	always @(posedge amp_cs) begin
		if (amp_bits > 0) begin
			amp_word  = amp_shift;
			amp_words = amp_words + 1;
		end
	end

	////////////////////
	// ADC model
	////////////////////

	logic [ADC_W-1:0] next_a = '0;
	logic [ADC_W-1:0] next_b = '0;
	// Slot 1 at the top, guard slots hold nonzero filler
	logic [33:0]      frame  = '0;
	int               conv_count  = 0;
	int               sck_total   = 0;
	int               sck_at_conv = 0;
	int               last_clocks = 0;

	assign adc_miso = frame[33];

	// Load on convert, advance on falling serial clock
	always @(posedge ad_conv or negedge adc_sck) begin
		if (ad_conv) begin
			frame       = {2'b10, next_a, 2'b01, next_b, 2'b11};
			conv_count  = conv_count + 1;
			last_clocks = sck_total - sck_at_conv;
			sck_at_conv = sck_total;
		end else begin
			frame = {frame[32:0], 1'b0};
		end
	end

	always @(posedge adc_sck) begin
		sck_total = sck_total + 1;
	end

	////////////////////
	// Helpers
	////////////////////

	logic [31:0] lcg_state = 32'd37;

	function automatic logic [ADC_W-1:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return ADC_W'(lcg_state >> 16);
	endfunction

	// Low or high byte of a sample, high part zero filled
	function automatic logic [LED_W-1:0] channel_byte(input logic [ADC_W-1:0] value,
			input logic upper);
		logic [ADC_W-1:0] shifted;
		if (upper) begin
			shifted = value >> 8;
		end else begin
			shifted = value;
		end
		return shifted[LED_W-1:0];
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "testbench stopped at first error");
	endtask

	task automatic check_led(input string name, input logic [LED_W-1:0] exp,
			input logic [LED_W-1:0] act);
		if (act !== exp) begin
			fail_run($sformatf("mismatch %s: expected 0x%02h, actual 0x%02h", name, exp, act));
		end
	endtask

	task automatic check_amp_word(input string name, input logic [AMP_WORD_W-1:0] exp,
			input logic [AMP_WORD_W-1:0] act);
		if (act !== exp) begin
			fail_run($sformatf("mismatch %s: expected 0x%02h, actual 0x%02h", name, exp, act));
		end
	endtask

	task automatic check_pin(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	// Counts ad_conv pulses, one period plus margin each
	task automatic wait_conversions(input string name, input int n);
		int start;
		int cycles;
		start  = conv_count;
		cycles = 0;
		while (conv_count < start + n) begin
			@(negedge CLK50MHZ);
			cycles = cycles + 1;
			if (cycles > n * (SAMPLE_PERIOD + 200)) begin
				fail_run($sformatf("%s: ad_conv pulses stopped arriving", name));
			end
		end
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (por_rst) begin
			@(negedge CLK50MHZ);
			cycles = cycles + 1;
			if (cycles > 100) begin
				fail_run("power on reset never released");
			end
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic check_reset_state(input string name);
		check_led({name, "_led"}, LED_RESET, led);
		check_pin({name, "_amp_cs"}, 1'b1, amp_cs);
		check_pin({name, "_ad_conv"}, 1'b0, ad_conv);
		check_pin({name, "_amp_sck"}, 1'b0, amp_sck);
		check_pin({name, "_adc_sck"}, 1'b0, adc_sck);
	endtask

	// One gain word, then nothing on the preamp until conversions run
	task automatic test_amp_word(input string name, input int frames_before,
			input int words_before);
		int cycles;
		cycles = 0;
		while (amp_words <= words_before) begin
			@(negedge CLK50MHZ);
			cycles = cycles + 1;
			if (cycles > 500) begin
				fail_run($sformatf("%s: preamp chip select never completed a word", name));
			end
		end
		if (amp_bits != AMP_WORD_W) begin
			fail_run($sformatf("%s: preamp frame had %0d serial clocks", name, amp_bits));
		end
		check_amp_word(name, {GAIN_B, GAIN_A}, amp_word);
		wait_conversions(name, 1);
		if (amp_frames != frames_before + 1) begin
			fail_run($sformatf("%s: extra preamp chip select cycle seen", name));
		end
	endtask

	task automatic test_channel_byte(input led_sel_t sel, input int rounds);
		logic [ADC_W-1:0] a;
		logic [ADC_W-1:0] b;
		logic [LED_W-1:0] exp;
		for (int r = 0; r < rounds; r++) begin
			a      = lcg_next();
			b      = lcg_next();
			sw     = sel;
			next_a = a;
			next_b = b;
			// First pulse carries the new samples, second shows them landed
			wait_conversions(sel.name(), 2);
			if (last_clocks != 34) begin
				fail_run($sformatf("%s: ADC frame had %0d serial clocks", sel.name(),
					last_clocks));
			end
			case (sel)
				SEL_A_LO: exp = channel_byte(a, 1'b0);
				SEL_A_HI: exp = channel_byte(a, 1'b1);
				SEL_B_LO: exp = channel_byte(b, 1'b0);
				default:  exp = channel_byte(b, 1'b1);
			endcase
			check_led(sel.name(), exp, led);
		end
	endtask

	task automatic test_amp_readback();
		sw = SEL_AMP;
		wait_conversions("amp_readback", 2);
		check_led("amp_readback", AMP_READBACK, led);
	endtask

	task automatic test_unlisted_code(input logic [3:0] code);
		string name;
		name   = $sformatf("unlisted_code_%0d", code);
		sw     = code;
		next_a = lcg_next();
		next_b = lcg_next();
		wait_conversions(name, 2);
		check_led(name, LED_OTHER, led);
	endtask

	task automatic test_midrun_reset();
		int frames;
		int words;
		frames  = amp_frames;
		words   = amp_words;
		mid_rst = 1'b1;
		repeat (16) @(negedge CLK50MHZ);
		check_reset_state("midrun_reset_held");
		mid_rst = 1'b0;
		@(negedge CLK50MHZ);
		check_reset_state("midrun_reset_released");
		test_amp_word("amp_word_after_reset", frames, words);
		test_channel_byte(SEL_B_LO, 1);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		sw     = SEL_A_LO;
		next_a = '0;
		next_b = '0;
		// Still inside power on reset here
		repeat (4) @(negedge CLK50MHZ);
		check_reset_state("reset_held");
		wait_reset_release();
		check_reset_state("reset_released");
		test_amp_word("amp_word_boot", 0, 0);
		test_channel_byte(SEL_A_LO, 3);
		test_channel_byte(SEL_A_HI, 3);
		test_channel_byte(SEL_B_LO, 3);
		test_channel_byte(SEL_B_HI, 3);
		test_amp_readback();
		test_unlisted_code(4'd0);
		test_unlisted_code(4'd15);
		test_unlisted_code(4'd6);
		test_midrun_reset();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 16
) (
	output logic CLK50MHZ,
	output logic RST
);

	// Free running board clock
	initial begin
		CLK50MHZ = 1'b0;
		forever #(PERIOD / 2) CLK50MHZ = ~CLK50MHZ;
	end

	// Power on reset, released on a falling edge
	initial begin
		RST = 1'b1;
		repeat (RST_CYCLES) @(negedge CLK50MHZ);
		RST <= 1'b0;
	end

endmodule

`default_nettype wire
